/* all.f */
+incdir+common
common/acc_pkg.sv
common/unit_result_if.sv
design/phase_sequencer.sv
design/operate_unit.sv
design/memref_unit.sv
eae/mul_unit.sv
design/acc_regs.sv
design/acc_top.sv
sim/tb_clock.sv
sim/acc_tb.sv

/* common/acc_consts.svh */
//==========================================================================
// Constants for the accumulator datapath: word width, multiply length,
// opcode field values and micro-op bit positions.
// Bit positions count left to right as in PDP-8 documentation.
// Include this header wherever the instruction word gets decoded.
//==========================================================================

`ifndef ACC_CONSTS_SVH
`define ACC_CONSTS_SVH

`define ACC_WORD_W      12
`define ACC_MUL_STEPS   12

// opcode field, bits 0 to 2
`define OP_AND          3'o0
`define OP_TAD          3'o1
`define OP_DCA          3'o3
`define OP_OPR          3'o7

`define MUL_INSTR       12'o7405

// group-1 micro-ops
`define CLA_BIT         4
`define CLL_BIT         5
`define CMA_BIT         6
`define CML_BIT         7
`define ROT_MSB         8
`define ROT_LSB         10
`define IAC_BIT         11

// group-3 micro-ops
`define MQA_BIT         5
`define MQL_BIT         7

// group select
`define GRP_BIT         3
`define GRP3_BIT        11

`endif

/* common/acc_pkg.sv */
//==========================================================================
// Shared types for the accumulator datapath.
// Words use the PDP-8 numbering, bit 0 being the most significant bit.
// Modules import this package inside their bodies and use scoped names
// for the port types.
//==========================================================================

package acc_pkg;

    // one machine word, left-to-right numbering
    typedef logic [0:11] word_t;

    // instruction phases, one per clock while busy
    typedef enum logic [2:0] {
        IDLE,   // waiting for start
        F1,     // clears and complements, group-3 MQ ops
        F2,     // increment
        F3,     // rotates
        E2,     // AND / TAD
        E3,     // DCA
        MUL,    // multiply iterations
        DONE    // result valid, done pulse
    } phase_e;

    typedef logic [3:0] step_t;  // multiply step count

endpackage

/* common/unit_result_if.sv */
//==========================================================================
// Result bundle of one execution unit: the proposed AC, link and MQ and
// a write enable. The unit side drives it, the register file reads it.
// A unit raises wr only during its own phases.
//==========================================================================

`timescale 1ns/100ps

interface unit_result_if;
    import acc_pkg::*;

    word_t ac;      // proposed accumulator
    logic  link;    // proposed link
    word_t mq;      // proposed MQ
    logic  wr;      // load all three this cycle

    modport unit (
        output ac, link, mq, wr
    );

    modport regs (
        input ac, link, mq, wr
    );

endinterface

/* design/acc_regs.sv */
//==========================================================================
// AC, link and MQ registers. Each edge loads from whichever execution
// unit asserts its write enable; the units never write in the same
// cycle, so the order below only sets a fixed priority.
// All three registers clear on reset.
//==========================================================================

`timescale 1ns/100ps

module acc_regs (
    input  logic           clk,
    input  logic           rst_n,
    unit_result_if.regs    opr,
    unit_result_if.regs    mem,
    unit_result_if.regs    mul,
    output acc_pkg::word_t ac,
    output logic           link,
    output acc_pkg::word_t mq
);
    import acc_pkg::*;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ac   <= '0;
            link <= 1'b0;
            mq   <= '0;
        end
        else if (opr.wr)
        begin
            ac   <= opr.ac;
            link <= opr.link;
            mq   <= opr.mq;
        end
        else if (mem.wr)
        begin
            ac   <= mem.ac;
            link <= mem.link;
            mq   <= mq;     // memory ops leave MQ alone
        end
        else if (mul.wr)
        begin
            ac   <= mul.ac;
            link <= mul.link;
            mq   <= mul.mq;
        end
    end

endmodule

/* design/acc_top.sv */
//==========================================================================
// Top level of the accumulator datapath. Connects the phase sequencer,
// the three execution units and the register file.
// Pulse start with an instruction word while busy is low; the operand
// is expected on mdout. done marks the cycle the results become valid.
//==========================================================================

`timescale 1ns/100ps

module acc_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  acc_pkg::word_t instruction,
    input  acc_pkg::word_t mdout,
    output acc_pkg::word_t ac,
    output logic           link,
    output acc_pkg::word_t mq,
    output logic           busy,
    output logic           done
);
    import acc_pkg::*;

    phase_e phase;
    word_t  instr;      // latched instruction
    logic   mul_last;

    unit_result_if opr_res ();
    unit_result_if mem_res ();
    unit_result_if mul_res ();

    phase_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .instruction (instruction),
        .mul_last    (mul_last),
        .phase       (phase),
        .instr       (instr),
        .busy        (busy),
        .done        (done)
    );

    operate_unit u_opr (
        .phase (phase),
        .instr (instr),
        .ac    (ac),
        .link  (link),
        .mq    (mq),
        .res   (opr_res.unit)
    );

    memref_unit u_mem (
        .phase (phase),
        .instr (instr),
        .ac    (ac),
        .link  (link),
        .mdout (mdout),
        .res   (mem_res.unit)
    );

    mul_unit u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .phase    (phase),
        .ac       (ac),
        .link     (link),
        .mq       (mq),
        .mdout    (mdout),
        .mul_last (mul_last),
        .res      (mul_res.unit)
    );

    acc_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .opr   (opr_res.regs),
        .mem   (mem_res.regs),
        .mul   (mul_res.regs),
        .ac    (ac),
        .link  (link),
        .mq    (mq)
    );

endmodule

/* design/memref_unit.sv */
//==========================================================================
// Memory-reference unit. AND and TAD combine AC with the operand on
// mdout during E2; DCA clears AC during E3 (the store is done outside).
// MQ is never changed here.
//==========================================================================

`timescale 1ns/100ps
`include "acc_consts.svh"

module memref_unit (
    input  acc_pkg::phase_e phase,
    input  acc_pkg::word_t  instr,
    input  acc_pkg::word_t  ac,
    input  logic            link,
    input  acc_pkg::word_t  mdout,
    unit_result_if.unit     res
);
    import acc_pkg::*;

    logic [2:0]           opcode;
    logic [`ACC_WORD_W:0] tad_sum;  // link and AC plus operand

    assign opcode  = instr[0:2];
    assign tad_sum = {link, ac} + {1'b0, mdout};

    always_comb
    begin
        res.ac   = ac;
        res.link = link;
        res.mq   = '0;
        res.wr   = 1'b0;
        if (phase == E2 && opcode == `OP_AND)
        begin
            res.ac = ac & mdout;
            res.wr = 1'b1;
        end
        else if (phase == E2 && opcode == `OP_TAD)
        begin
            {res.link, res.ac} = tad_sum;  // carry out flips the link
            res.wr = 1'b1;
        end
        else if (phase == E3 && opcode == `OP_DCA)
        begin
            res.ac = '0;
            res.wr = 1'b1;
        end
    end

endmodule

/* design/operate_unit.sv */
//==========================================================================
// Operate-instruction unit. Group 1 runs clears and complements in F1,
// the increment in F2 and one rotate or byte swap in F3. Group 3 runs
// CLA followed by MQA, MQL or both (swap) in F1.
// Purely combinational; the proposal is written only during those phases.
//==========================================================================

`timescale 1ns/100ps
`include "acc_consts.svh"

module operate_unit (
    input  acc_pkg::phase_e phase,
    input  acc_pkg::word_t  instr,
    input  acc_pkg::word_t  ac,
    input  logic            link,
    input  acc_pkg::word_t  mq,
    unit_result_if.unit     res
);
    import acc_pkg::*;

    logic  is_opr;
    logic  grp1;
    logic  grp3;
    word_t ac_clr;     // AC after CLA
    logic  link_clr;   // link after CLL
    logic  [2:0] rot;

    assign is_opr   = (instr[0:2] == `OP_OPR);
    assign grp1     = is_opr && !instr[`GRP_BIT];
    assign grp3     = is_opr && instr[`GRP_BIT] && instr[`GRP3_BIT];
    assign ac_clr   = instr[`CLA_BIT] ? '0 : ac;
    assign link_clr = instr[`CLL_BIT] ? 1'b0 : link;
    assign rot      = instr[`ROT_MSB:`ROT_LSB];

    always_comb
    begin
        res.ac   = ac;
        res.link = link;
        res.mq   = mq;
        res.wr   = 1'b0;
        case (phase)
            F1:
            begin
                if (grp1)
                begin
                    res.ac   = instr[`CMA_BIT] ? ~ac_clr : ac_clr;
                    res.link = instr[`CML_BIT] ? ~link_clr : link_clr;
                    res.wr   = 1'b1;
                end
                else if (grp3)
                begin
                    case ({instr[`MQA_BIT], instr[`MQL_BIT]})
                        2'b10: res.ac = ac_clr | mq;   // MQA
                        2'b01:                         // MQL
                        begin
                            res.mq = ac_clr;
                            res.ac = '0;
                        end
                        2'b11:                         // SWP
                        begin
                            res.mq = ac_clr;
                            res.ac = mq;
                        end
                        default: res.ac = ac_clr;
                    endcase
                    res.wr = 1'b1;
                end
            end
            F2:
            begin
                if (grp1 && instr[`IAC_BIT])
                begin
                    {res.link, res.ac} = {link, ac} + 1'b1;  // carry toggles link
                    res.wr = 1'b1;
                end
            end
            F3:
            begin
                if (grp1)
                begin
                    case (rot)
                        3'b001: res.ac = {ac[6:11], ac[0:5]};  // BSW
                        3'b010:                                // RAL
                        begin
                            res.ac   = {ac[1:11], link};
                            res.link = ac[0];
                        end
                        3'b011:                                // RTL
                        begin
                            res.ac   = {ac[2:11], link, ac[0]};
                            res.link = ac[1];
                        end
                        3'b100:                                // RAR
                        begin
                            res.ac   = {link, ac[0:10]};
                            res.link = ac[11];
                        end
                        3'b101:                                // RTR
                        begin
                            res.ac   = {ac[11], link, ac[0:9]};
                            res.link = ac[10];
                        end
                        default: ;                             // no shift
                    endcase
                    res.wr = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* design/phase_sequencer.sv */
//==========================================================================
// Phase sequencer for the accumulator datapath.
// A start pulse seen while idle latches the instruction word and steps
// the machine through F1, F2, F3, E2 and E3. The MUL instruction then
// stays in the MUL phase until the multiplier flags its last step.
// Every instruction ends with one DONE cycle, which raises done.
//==========================================================================

`timescale 1ns/100ps
`include "acc_consts.svh"

module phase_sequencer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  acc_pkg::word_t instruction,
    input  logic           mul_last,
    output acc_pkg::phase_e phase,
    output acc_pkg::word_t instr,
    output logic           busy,
    output logic           done
);
    import acc_pkg::*;

    phase_e phase_nxt;

    always_comb
    begin
        phase_nxt = phase;
        case (phase)
            IDLE, DONE: phase_nxt = start ? F1 : IDLE;  // DONE may chain a new start
            F1:         phase_nxt = F2;
            F2:         phase_nxt = F3;
            F3:         phase_nxt = E2;
            E2:         phase_nxt = E3;
            E3:         phase_nxt = (instr == `MUL_INSTR) ? MUL : DONE;
            MUL:
            begin
                if (mul_last)
                    phase_nxt = DONE;
            end
            default:    phase_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            phase <= IDLE;
        else
            phase <= phase_nxt;
    end

    // instruction is captured only when a new one is accepted
    always_ff @(posedge clk)
    begin
        if (start && !busy)
            instr <= instruction;
    end

    assign busy = (phase != IDLE) && (phase != DONE);
    assign done = (phase == DONE);

endmodule

/* eae/mul_unit.sv */
//==========================================================================
// EAE multiplier. One shift-and-add step per MUL cycle: when the MQ
// least significant bit is set the operand is added to AC, then the
// carry, AC and MQ shift right together. After twelve steps {AC,MQ}
// holds AC + MQ * mdout and the link is clear.
// mul_last tells the sequencer that the current step is the final one.
//==========================================================================

`timescale 1ns/100ps
`include "acc_consts.svh"

module mul_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  acc_pkg::phase_e phase,
    input  acc_pkg::word_t  ac,
    input  logic            link,
    input  acc_pkg::word_t  mq,
    input  acc_pkg::word_t  mdout,
    output logic            mul_last,
    unit_result_if.unit     res
);
    import acc_pkg::*;

    step_t                step_cnt;
    word_t                addend;
    logic [`ACC_WORD_W:0] sum;      // carry and partial AC

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            step_cnt <= '0;
        else if (phase == MUL)
            step_cnt <= step_cnt + 1'b1;
        else
            step_cnt <= '0;  // ready for the next multiply
    end

    assign mul_last = (phase == MUL) && (step_cnt == step_t'(`ACC_MUL_STEPS - 1));

    assign addend = mq[`ACC_WORD_W-1] ? mdout : '0;  // multiplier bit
    assign sum    = {1'b0, ac} + {1'b0, addend};

    always_comb
    begin
        res.ac   = sum[`ACC_WORD_W:1];
        res.mq   = {sum[0], mq[0:`ACC_WORD_W-2]};  // low sum bit enters MQ
        res.link = 1'b0;                            // MUL clears the link
        res.wr   = (phase == MUL);
    end

endmodule

/* run.sh */
#!/bin/sh
# build the accumulator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module acc_tb -o acc_sim
out=$(./obj_dir/acc_sim)
echo "$out"
if echo "$out" | grep -qx '>>> PASS'
then
    exit 0
fi
exit 1

/* sim/acc_tb.sv */
//==========================================================================
// Testbench for the accumulator datapath top level.
// Issues operate, memory-reference and MUL instructions, predicts each
// result with a behavioral model and checks AC, link, MQ, busy and done
// timing around every instruction. Ends with an error summary line.
//==========================================================================

`timescale 1ns/100ps
`include "acc_consts.svh"

module acc_tb;
    import acc_pkg::*;

    typedef struct packed
    {
        word_t ac;
        logic  link;
        word_t mq;
    } acc_state_t;

    // instructions per test, used to size the watchdog
    localparam int N_INSTR    = 1 + 16 * 4 + (16 * 4 + 2 * 4) + (8 * 9 + 4) + 16 * 8 + 8 * 8;
    localparam int RST_CYCLES = 16;
    localparam int WD_CYCLES  = N_INSTR * 20 + RST_CYCLES;

    logic       clk;
    logic       rst_n;
    logic       start;
    word_t      instruction;
    word_t      mdout;
    word_t      ac;
    logic       link;
    word_t      mq;
    logic       busy;
    logic       done;
    integer     seed;
    int         err_value;
    int         err_timing;
    int         err_other;
    int         cycle_cnt;
    int         start_cycle;
    int         exp_latency;
    int         done_cnt;
    int         issued_cnt;  // accepted starts so far
    acc_state_t model;     // state after the last finished instruction
    acc_state_t expected;  // prediction for the instruction in flight

    tb_clock #(.PERIOD(100), .RST_CYCLES(RST_CYCLES)) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    acc_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .instruction (instruction),
        .mdout       (mdout),
        .ac          (ac),
        .link        (link),
        .mq          (mq),
        .busy        (busy),
        .done        (done)
    );

    function automatic acc_state_t acc_model(input word_t ins, input word_t md,
                                             input acc_state_t old);
        acc_state_t  s;
        logic [12:0] lac;    // link above AC
        logic [12:0] sum13;
        logic [23:0] prod;
        word_t       a;
        word_t       mq_old;
        s = old;
        if (ins == `MUL_INSTR)
        begin
            prod   = 24'(old.ac) + 24'(old.mq) * 24'(md);
            s.ac   = prod[23:12];
            s.mq   = prod[11:0];
            s.link = 1'b0;
        end
        else if (ins[0:2] == `OP_OPR && !ins[`GRP_BIT])
        begin
            if (ins[`CLA_BIT])
                s.ac = '0;
            if (ins[`CLL_BIT])
                s.link = 1'b0;
            if (ins[`CMA_BIT])
                s.ac = ~s.ac;
            if (ins[`CML_BIT])
                s.link = ~s.link;
            lac = {s.link, s.ac};
            if (ins[`IAC_BIT])
                lac = lac + 13'd1;
            case (ins[`ROT_MSB:`ROT_LSB])
                3'b001:  lac = {lac[12], lac[5:0], lac[11:6]};  // halves swap
                3'b010:  lac = {lac[11:0], lac[12]};
                3'b011:  lac = {lac[10:0], lac[12:11]};
                3'b100:  lac = {lac[0], lac[12:1]};
                3'b101:  lac = {lac[1:0], lac[12:2]};
                default: ;
            endcase
            {s.link, s.ac} = lac;
        end
        else if (ins[0:2] == `OP_OPR && ins[`GRP3_BIT])
        begin
            a      = ins[`CLA_BIT] ? 12'o0 : s.ac;
            mq_old = s.mq;
            if (ins[`MQL_BIT])
                s.mq = a;
            s.ac = (ins[`MQA_BIT] ? mq_old : 12'o0) | (ins[`MQL_BIT] ? 12'o0 : a);
        end
        else if (ins[0:2] == `OP_AND)
            s.ac = old.ac & md;
        else if (ins[0:2] == `OP_TAD)
        begin
            sum13  = {1'b0, old.ac} + {1'b0, md};
            s.ac   = sum13[11:0];
            s.link = old.link ^ sum13[12];  // carry out flips the link
        end
        else if (ins[0:2] == `OP_DCA)
            s.ac = '0;
        return s;
    endfunction

    function automatic word_t rand_word();
        int r;
        r = $random(seed);
        return r[11:0];
    endfunction

    function automatic logic rand_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
        if (act_v !== exp_v)
        begin
            $display("ERR t=%0t %s expected %o actual %o", $time, name, exp_v, act_v);
            err_value++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
        begin
            $display("ERR t=%0t %s expected %b actual %b", $time, name, exp_v, act_v);
            err_value++;
        end
    endtask

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // results are checked mid-cycle while done is high
    always @(negedge clk)
    begin
        logic exp_busy;
        // busy covers the cycles after the accepted start, up to done
        exp_busy = (issued_cnt != done_cnt) && (cycle_cnt > start_cycle)
                   && (cycle_cnt - start_cycle < exp_latency);
        if (rst_n)
        begin
            check_bit("busy", exp_busy, busy);
            if (done)
            begin
                check_word("ac", expected.ac, ac);
                check_bit("link", expected.link, link);
                check_word("mq", expected.mq, mq);
                if (cycle_cnt - start_cycle != exp_latency)
                begin
                    $display("done arrived %0d cycles after start at t=%0t, expected %0d",
                             cycle_cnt - start_cycle, $time, exp_latency);
                    err_timing++;
                end
                done_cnt++;
            end
        end
    end

    // poke raises start again while busy, which the DUT must ignore
    task automatic run_instr(input word_t ins, input word_t md, input logic poke = 1'b0);
        int seen;
        int waited;
        expected = acc_model(ins, md, model);
        seen     = done_cnt;
        waited   = 0;
        @(posedge clk);
        #10;
        instruction = ins;
        mdout       = md;
        start       = 1'b1;
        start_cycle = cycle_cnt;
        exp_latency = (ins == `MUL_INSTR) ? 18 : 6;
        issued_cnt++;
        @(posedge clk);
        #10;
        start = 1'b0;
        if (poke)
        begin
            @(posedge clk);
            #10;
            start       = 1'b1;
            instruction = 12'o7040;  // CMA, must not run
            @(posedge clk);
            #10;
            start       = 1'b0;
            instruction = ins;
        end
        while (done_cnt == seen && waited < 40)
        begin
            @(posedge clk);
            waited++;
        end
        if (done_cnt == seen)
        begin
            $display("no done within 40 cycles for instruction %o at t=%0t", ins, $time);
            err_other++;
        end
        model = expected;
    endtask

    task automatic load_ac(input word_t v, input logic l);
        run_instr(12'o7300, 12'o0);          // CLA CLL
        run_instr({`OP_TAD, 9'o123}, v);
        if (l)
            run_instr(12'o7020, 12'o0);      // CML
    endtask

    task automatic load_mq(input word_t v);
        load_ac(v, 1'b0);
        run_instr(12'o7421, 12'o0);          // MQL
    endtask

    initial
    begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, test did not finish", WD_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        word_t ins;
        start       = 1'b0;
        instruction = '0;
        mdout       = '0;
        seed        = 32'hc64e5c3a;
        err_value   = 0;
        err_timing  = 0;
        err_other   = 0;
        cycle_cnt   = 0;
        start_cycle = 0;
        exp_latency = 6;
        done_cnt    = 0;
        issued_cnt  = 0;
        model       = '0;
        expected    = '0;

        @(posedge rst_n);
        @(negedge clk);
        check_word("ac", 12'o0, ac);
        check_bit("link", 1'b0, link);
        check_word("mq", 12'o0, mq);
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);

        run_instr(12'o7001, 12'o0, 1'b1);    // IAC with a stray start
        repeat (10)
        begin
            @(negedge clk);
            if (busy || done)
            begin
                $display("ignored start ran a second instruction at t=%0t", $time);
                err_other++;
            end
        end

        for (int i = 0; i < 16; i++)
        begin
            load_ac(rand_word(), rand_bit());
            ins = 12'o7000;
            ins[`CLA_BIT] = i[3];
            ins[`CLL_BIT] = i[2];
            ins[`CMA_BIT] = i[1];
            ins[`CML_BIT] = i[0];
            run_instr(ins, rand_word());
        end

        for (int i = 0; i < 16; i++)
        begin
            load_ac(rand_word(), rand_bit());
            ins = 12'o7000;
            ins[`ROT_MSB:`ROT_LSB] = i[2:0];
            ins[`IAC_BIT] = i[3];
            run_instr(ins, 12'o0);
        end
        for (int l = 0; l < 2; l++)
        begin
            load_ac(12'o7777, l[0]);         // IAC overflow into the link
            run_instr(12'o7001, 12'o0);
        end

        for (int k = 0; k < 8; k++)
        begin
            load_ac(rand_word(), rand_bit());
            run_instr({`OP_TAD, 9'o200}, rand_word());
            load_ac(rand_word(), rand_bit());
            run_instr({`OP_AND, 9'o017}, rand_word());
            run_instr({`OP_DCA, 9'o040}, rand_word());
        end
        load_ac(12'o7777, 1'b0);
        run_instr({`OP_TAD, 9'o000}, 12'o0001);

        for (int k = 0; k < 16; k++)
        begin
            load_mq(rand_word());
            load_ac(rand_word(), rand_bit());
            ins = 12'o7401;
            ins[`CLA_BIT] = k[2];
            ins[`MQA_BIT] = k[1];
            ins[`MQL_BIT] = k[0];
            run_instr(ins, 12'o0);
        end

        for (int k = 0; k < 8; k++)
        begin
            load_mq(rand_word());
            load_ac(rand_word(), rand_bit());
            run_instr(`MUL_INSTR, rand_word());
        end

        repeat (4) @(posedge clk);
        $display("errors: value %0d, timing %0d, other %0d", err_value, err_timing, err_other);
        if (err_value + err_timing + err_other == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
//==========================================================================
// Clock and reset source for the accumulator testbench.
// Free-running clock of PERIOD ns; rst_n is held low for RST_CYCLES
// rising edges and released shortly after the last one.
//==========================================================================

`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;  // released off the edge, like other inputs
    end

endmodule
